/* verilog/tc_pkg.sv */
package tc_pkg;

    // device bus.
    localparam int DEV_ADDR_WD = 3;     // msb picks the timer.
    localparam int DATA_WD     = 32;
    localparam int REG_AW      = 2;     // register word address inside a timer.

    // ctrl register layout.
    localparam int CTRL_WD       = 4;
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_MODE_LSB = 1;
    localparam int MODE_WD       = 2;
    localparam int CTRL_IM_BIT   = 3;   // interrupt mask.

    // counting modes.
    typedef enum logic [MODE_WD-1:0] {
        MODE_ONESHOT = 2'd0,
        MODE_RELOAD  = 2'd1,
        MODE_RSV2    = 2'd2,
        MODE_RSV3    = 2'd3
    } tc_mode_e;

    // word 3 of the register map is unmapped.
    typedef enum logic [REG_AW-1:0] {
        REG_CTRL   = 2'd0,
        REG_PRESET = 2'd1,
        REG_COUNT  = 2'd2
    } tc_reg_e;

endpackage

/* verilog/tc_bus_if.sv */
`timescale 1ns/1ps

interface tc_bus_if;
    import tc_pkg::*;

    logic               we;     // write strobe for this timer only.
    tc_reg_e            add;
    logic [DATA_WD-1:0] dat_w;
    logic [DATA_WD-1:0] dat_r;  // combinational read back.

    // decoder side.
    modport host (
        output we,
        output add,
        output dat_w,
        input  dat_r
    );

    // timer side.
    modport dev (
        input  we,
        input  add,
        input  dat_w,
        output dat_r
    );

endinterface

/* verilog/tc_timer.sv */
`timescale 1ns/1ps

module tc_timer (
    input  logic  clk_i,
    input  logic  rst_i,
    tc_bus_if.dev bus,
    output logic  irq_o
);
    import tc_pkg::*;

    logic [CTRL_WD-1:0] ctrl_q;
    logic [DATA_WD-1:0] preset_q;
    logic [DATA_WD-1:0] count_q;
    logic [DATA_WD-1:0] count_d;

    logic     ctrl_en;
    logic     ctrl_im;
    tc_mode_e ctrl_mode;
    tc_mode_e wr_mode;
    logic     ctrl_wr;
    logic     preset_wr;
    logic     cnt_zero;
    logic     cnt_load;

    // only the two defined modes ever move the counter.
    function automatic logic mode_runs(input tc_mode_e mode);
        return (mode == MODE_ONESHOT) || (mode == MODE_RELOAD);
    endfunction

    assign ctrl_en   = ctrl_q[CTRL_EN_BIT];
    assign ctrl_im   = ctrl_q[CTRL_IM_BIT];
    assign ctrl_mode = tc_mode_e'(ctrl_q[CTRL_MODE_LSB +: MODE_WD]);
    assign wr_mode   = tc_mode_e'(bus.dat_w[CTRL_MODE_LSB +: MODE_WD]);

    assign ctrl_wr   = bus.we && (bus.add == REG_CTRL);
    assign preset_wr = bus.we && (bus.add == REG_PRESET);
    assign cnt_zero  = (count_q == '0);

    // enabling write starts a fresh run from preset.
    assign cnt_load = ctrl_wr && bus.dat_w[CTRL_EN_BIT] && mode_runs(wr_mode);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q   <= '0;
            preset_q <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= bus.dat_w[CTRL_WD-1:0];   // upper bits dropped.
            end
            if (preset_wr) begin
                preset_q <= bus.dat_w;
            end
        end
    end

    // next count.
    always_comb begin
        count_d = count_q;
        if (ctrl_wr) begin
            if (cnt_load) begin
                count_d = preset_q;
            end
        end else if (ctrl_en && mode_runs(ctrl_mode)) begin
            if (!cnt_zero) begin
                count_d = count_q - 1'b1;
            end else if (ctrl_mode == MODE_RELOAD) begin
                count_d = preset_q;     // wrap back to preset.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // one-shot holds irq at zero, reload gives a single cycle pulse.
    always_comb begin
        case (ctrl_mode)
            MODE_ONESHOT: irq_o = ctrl_im && cnt_zero;
            MODE_RELOAD:  irq_o = ctrl_im && ctrl_en && cnt_zero;
            default:      irq_o = 1'b0;
        endcase
    end

    // register read back.
    always_comb begin
        case (bus.add)
            REG_CTRL:   bus.dat_r = {{(DATA_WD-CTRL_WD){1'b0}}, ctrl_q};
            REG_PRESET: bus.dat_r = preset_q;
            REG_COUNT:  bus.dat_r = count_q;
            default:    bus.dat_r = '0;
        endcase
    end

    // count is frozen while disabled.
    a_count_frozen: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (!ctrl_en && !ctrl_wr) |=> $stable(count_q)
    ) else $error("count moved while timer disabled");

    // masked timer stays quiet.
    a_irq_masked: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !ctrl_im |-> !irq_o
    ) else $error("irq high with mask clear");

endmodule

/* verilog/tc_bus_decoder.sv */
`timescale 1ns/1ps

module tc_bus_decoder (
    input  logic [tc_pkg::DEV_ADDR_WD-1:0] add_i,
    input  logic                           we_i,
    input  logic [tc_pkg::DATA_WD-1:0]     dat_i,
    output logic [tc_pkg::DATA_WD-1:0]     dat_o,
    tc_bus_if.host                         tmr0,
    tc_bus_if.host                         tmr1
);
    import tc_pkg::*;

    logic    tmr_sel;
    tc_reg_e reg_add;
    logic    unmapped;
    logic    wr_ok;

    assign tmr_sel  = add_i[DEV_ADDR_WD-1];          // 0 is timer 0.
    assign reg_add  = tc_reg_e'(add_i[REG_AW-1:0]);
    assign unmapped = !(reg_add inside {REG_CTRL, REG_PRESET, REG_COUNT});
    assign wr_ok    = we_i && !unmapped;

    // write strobe reaches only the selected timer.
    assign tmr0.we = wr_ok && !tmr_sel;
    assign tmr1.we = wr_ok && tmr_sel;

    // address and data fan out to both.
    assign tmr0.add   = reg_add;
    assign tmr1.add   = reg_add;
    assign tmr0.dat_w = dat_i;
    assign tmr1.dat_w = dat_i;

    always_comb begin
        if (unmapped) begin
            dat_o = '0;
        end else if (tmr_sel) begin
            dat_o = tmr1.dat_r;
        end else begin
            dat_o = tmr0.dat_r;
        end
    end

    // writes to the hole in the map are a host error.
    always_comb begin
        if (we_i) begin
            a_no_unmapped_wr: assert (!unmapped)
                else $error("write to unmapped register, add_i=%0d", add_i);
        end
    end

endmodule

/* verilog/tc_subsys_top.sv */
`timescale 1ns/1ps

module tc_subsys_top (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           we_i,
    input  logic [tc_pkg::DEV_ADDR_WD-1:0] add_i,
    input  logic [tc_pkg::DATA_WD-1:0]     dat_i,
    output logic [tc_pkg::DATA_WD-1:0]     dat_o,
    output logic                           irq0_o,
    output logic                           irq1_o
);

    // one register port per timer.
    tc_bus_if tmr0_bus ();
    tc_bus_if tmr1_bus ();

    tc_bus_decoder i_dec (
        .add_i (add_i),
        .we_i  (we_i),
        .dat_i (dat_i),
        .dat_o (dat_o),
        .tmr0  (tmr0_bus.host),
        .tmr1  (tmr1_bus.host)
    );

    // timer 0 at device words 0..2.
    tc_timer i_tmr0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (tmr0_bus.dev),
        .irq_o (irq0_o)
    );

    // timer 1 at device words 4..6.
    tc_timer i_tmr1 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (tmr1_bus.dev),
        .irq_o (irq1_o)
    );

endmodule

/* test/tc_subsys_tb.sv */
`timescale 1ns/1ps

module tc_subsys_tb;
    import tc_pkg::*;

    logic                   clk_i;
    logic                   rst_i;
    logic                   we_i;
    logic [DEV_ADDR_WD-1:0] add_i;
    logic [DATA_WD-1:0]     dat_i;
    logic [DATA_WD-1:0]     dat_o;
    logic                   irq0_o;
    logic                   irq1_o;

    // reference state with one entry per timer.
    logic [3:0]         m_ctrl   [2];
    logic [DATA_WD-1:0] m_preset [2];
    logic [DATA_WD-1:0] m_count  [2];
    logic [DATA_WD+1:0] exp_out;    // {irq1, irq0, dat_o}.

    integer             seed;
    logic [31:0]        rnd;
    logic [2:0]         rnd_add;
    int                 i;

    tc_subsys_top i_dut (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .we_i   (we_i),
        .add_i  (add_i),
        .dat_i  (dat_i),
        .dat_o  (dat_o),
        .irq0_o (irq0_o),
        .irq1_o (irq1_o)
    );

    always #4 clk_i = ~clk_i;   // 8 ns period.

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    // expected outputs for the current inputs, then the state after the next edge.
    function automatic logic [DATA_WD+1:0] tc_model(input logic we, input logic [2:0] add,
                                                   input logic [DATA_WD-1:0] dat);
        logic               sel;
        logic [1:0]         r;
        logic [1:0]         mode;
        logic               en;
        logic               run;
        logic [1:0]         irq;
        logic [DATA_WD-1:0] rd;

        sel = add[2];
        r   = add[1:0];
        for (int t = 0; t < 2; t++) begin
            mode   = m_ctrl[t][2:1];
            en     = m_ctrl[t][0];
            irq[t] = m_ctrl[t][3] && (m_count[t] == 0) &&
                     ((mode == 2'd0) || (mode == 2'd1 && en));
        end
        case (r)
            2'd0:    rd = {28'd0, m_ctrl[sel]};
            2'd1:    rd = m_preset[sel];
            2'd2:    rd = m_count[sel];
            default: rd = '0;
        endcase

        for (int t = 0; t < 2; t++) begin
            mode = m_ctrl[t][2:1];
            en   = m_ctrl[t][0];
            run  = en && (mode == 2'd0 || mode == 2'd1);
            if (we && sel == t[0] && r == 2'd0) begin
                if (dat[0] && dat[2:1] < 2'd2) begin
                    m_count[t] = m_preset[t];   // enable starts a new run.
                end
                m_ctrl[t] = dat[3:0];
            end else begin
                if (run && m_count[t] != 0) begin
                    m_count[t] = m_count[t] - 1;
                end else if (run && mode == 2'd1) begin
                    m_count[t] = m_preset[t];
                end
                if (we && sel == t[0] && r == 2'd1) begin
                    m_preset[t] = dat;
                end
            end
        end
        return {irq[1], irq[0], rd};
    endfunction

    // compare at the falling edge, where dat_o and irq are settled.
    always @(negedge clk_i) begin
        if (rst_i) begin
            for (int t = 0; t < 2; t++) begin
                m_ctrl[t]   = '0;
                m_preset[t] = '0;
                m_count[t]  = '0;
            end
        end else begin
            exp_out = tc_model(we_i, add_i, dat_i);
            assert (dat_o == exp_out[DATA_WD-1:0]) else
                fail_now($sformatf("Error: %0d ns dat_o %h, model %h at add %0d",
                                   $time, dat_o, exp_out[DATA_WD-1:0], add_i));
            assert (irq0_o == exp_out[DATA_WD]) else
                fail_now($sformatf("Error: %0d ns irq0_o %0b, model %0b",
                                   $time, irq0_o, exp_out[DATA_WD]));
            assert (irq1_o == exp_out[DATA_WD+1]) else
                fail_now($sformatf("Error: %0d ns irq1_o %0b, model %0b",
                                   $time, irq1_o, exp_out[DATA_WD+1]));
        end
    end

    task automatic bus_write(input logic [2:0] add, input logic [31:0] dat);
        @(posedge clk_i);
        #1;
        we_i  = 1'b1;
        add_i = add;
        dat_i = dat;
        @(negedge clk_i);
    endtask

    task automatic expect_read(input logic [2:0] add, input logic [31:0] exp);
        @(posedge clk_i);
        #1;
        we_i  = 1'b0;
        add_i = add;
        dat_i = '0;
        @(negedge clk_i);
        assert (dat_o == exp) else
            fail_now($sformatf("Error: %0d ns read at add %0d gave %h, expected %h",
                               $time, add, dat_o, exp));
    endtask

    task automatic check_irq(input logic exp0, input logic exp1);
        assert (irq0_o == exp0 && irq1_o == exp1) else
            fail_now($sformatf("Error: %0d ns irq0/irq1 %0b/%0b, expected %0b/%0b",
                               $time, irq0_o, irq1_o, exp0, exp1));
    endtask

    // poll one irq line while reading that timer's count.
    task automatic wait_irq(input bit idx, input logic level, input int limit);
        int   n;
        logic seen;

        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk_i);
            #1;
            we_i  = 1'b0;
            add_i = {idx, 2'd2};
            @(negedge clk_i);
            seen = ((idx ? irq1_o : irq0_o) == level);
            n++;
        end
        if (!seen) begin
            fail_now($sformatf("timeout: irq%0d did not go to %0b within %0d cycles",
                               idx, level, limit));
        end
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        we_i  = 1'b0;
        add_i = '0;
        dat_i = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // everything clear after reset.
        for (i = 0; i < 7; i++) begin
            if (i != 3) expect_read(3'(i), 32'd0);
        end
        check_irq(1'b0, 1'b0);

        // register access.
        bus_write(3'd0, 32'hffff_fff4);     // mode 2, disabled.
        expect_read(3'd0, 32'h0000_0004);
        bus_write(3'd0, 32'h0);
        bus_write(3'd1, 32'h1234_5678);
        expect_read(3'd1, 32'h1234_5678);
        bus_write(3'd2, 32'hdead_beef);     // count is read only.
        expect_read(3'd2, 32'd0);
        for (i = 4; i < 7; i++) begin
            expect_read(3'(i), 32'd0);
        end

        // one-shot run from 5.
        bus_write(3'd1, 32'd5);
        bus_write(3'd0, 32'h9);             // mask, one-shot, enable.
        for (i = 5; i >= 0; i--) begin
            expect_read(3'd2, 32'(i));
            check_irq(i == 0, 1'b0);
        end
        repeat (3) begin
            expect_read(3'd2, 32'd0);
            check_irq(1'b1, 1'b0);          // level held at zero.
        end
        bus_write(3'd0, 32'h0);
        expect_read(3'd2, 32'd0);
        check_irq(1'b0, 1'b0);

        // reload mode on timer 1.
        bus_write(3'd5, 32'd3);
        bus_write(3'd4, 32'hb);
        for (i = 0; i < 8; i++) begin
            expect_read(3'd6, 32'd3 - 32'(i % 4));
            check_irq(1'b0, (i % 4) == 3);
        end
        wait_irq(1'b1, 1'b1, 8);
        expect_read(3'd6, 32'd3);
        check_irq(1'b0, 1'b0);              // pulse lasts one cycle.

        // disable freezes the count.
        bus_write(3'd1, 32'd100);
        bus_write(3'd0, 32'h1);
        expect_read(3'd2, 32'd100);
        expect_read(3'd2, 32'd99);
        expect_read(3'd2, 32'd98);
        bus_write(3'd0, 32'h0);
        repeat (5) expect_read(3'd2, 32'd97);

        // both timers at once with random presets and traffic.
        seed = 32'he88a;
        rnd  = $random(seed);
        bus_write(3'd1, (rnd & 32'h1f) + 32'd1);
        rnd  = $random(seed);
        bus_write(3'd5, (rnd & 32'h1f) + 32'd1);
        bus_write(3'd0, 32'h9);
        bus_write(3'd4, 32'hb);
        wait_irq(1'b0, 1'b1, 40);
        for (i = 0; i < 300; i++) begin
            rnd     = $random(seed);
            rnd_add = rnd[2:0];
            if (rnd_add[1:0] == 2'd3) rnd_add[1:0] = 2'd2;
            @(posedge clk_i);
            #1;
            we_i  = (rnd[7:4] == 4'd0);     // write about one cycle in 16.
            add_i = rnd_add;
            dat_i = (rnd_add[1:0] == 2'd0) ? {28'd0, rnd[11:8]} : {24'd0, rnd[15:8]};
        end
        @(posedge clk_i);
        #1;
        we_i = 1'b0;
        repeat (2) @(negedge clk_i);

        $display("** PASS **");
        $finish;
    end

endmodule

/* all.f */
verilog/tc_pkg.sv
verilog/tc_bus_if.sv
verilog/tc_timer.sv
verilog/tc_bus_decoder.sv
verilog/tc_subsys_top.sv
test/tc_subsys_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tc_subsys_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
